// ==== source/ntm_product_pkg.sv ====
// Modular product accelerator shared widths, input word views and result types
`default_nettype none

package ntm_product_pkg;

  // Input word, operand and count widths
  parameter int WORD_W    = 32;
  parameter int DATA_SIZE = 16;
  parameter int LEN_W     = 8;

  // Header word with count on top and modulus at the bottom
  typedef struct packed {
    logic [LEN_W-1:0]                length;
    logic [WORD_W-LEN_W-DATA_SIZE-1:0] reserved;
    logic [DATA_SIZE-1:0]            modulo;
  } ntm_header_t;

  // Element word with the value in the low half
  typedef struct packed {
    logic [WORD_W-DATA_SIZE-1:0] reserved;
    logic [DATA_SIZE-1:0]        value;
  } ntm_element_t;

  // Same input word read as header or as element
  typedef union packed {
    ntm_header_t  header;
    ntm_element_t element;
  } ntm_in_word_u;

  // Tagged input beat
  typedef struct packed {
    logic         is_header;
    ntm_in_word_u word;
  } ntm_in_beat_t;

  // Sticky error flags
  typedef struct packed {
    logic overflow;
    logic header_drop;
  } ntm_status_t;

  // Final product with its status snapshot
  typedef struct packed {
    logic [DATA_SIZE-1:0] value;
    ntm_status_t          status;
  } ntm_result_t;

endpackage

`default_nettype wire

// ==== source/ntm_element_fifo.sv ====
// Input side that decodes tagged words, latches headers and buffers elements
`timescale 1ns/100ps
`default_nettype none

module ntm_element_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         in_valid,
  input  ntm_product_pkg::ntm_in_beat_t in_beat,
  input  logic                         elem_pop,
  input  logic                         busy,
  output logic                         vec_start,
  output ntm_product_pkg::ntm_header_t  vec_header,
  output ntm_product_pkg::ntm_element_t elem_data,
  output logic                         elem_empty,
  output ntm_product_pkg::ntm_status_t  status
);

  import ntm_product_pkg::*;

  localparam int ADDR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

  ntm_element_t      mem [FIFO_DEPTH];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_ptr;
  logic [ADDR_W:0]   count;
  ntm_header_t       hdr_word;
  ntm_element_t      elem_word;
  logic              hdr_in;
  logic              elem_in;
  logic              hdr_accept;
  logic              full;
  logic              push;

  //////////////////////////////////////////////////
  // Beat decode
  //////////////////////////////////////////////////

  // Two views of one word, selected by the tag
  assign hdr_word   = in_beat.word.header;
  assign elem_word  = in_beat.word.element;
  assign hdr_in     = in_valid && in_beat.is_header;
  assign elem_in    = in_valid && !in_beat.is_header;
  // Headers only start a vector when the controller is free
  assign hdr_accept = hdr_in && !busy;

  // A pop in the same cycle frees a slot for the push
  assign full       = (count == (ADDR_W+1)'(FIFO_DEPTH));
  assign push       = elem_in && (!full || elem_pop);
  assign elem_empty = (count == '0);
  // Show-ahead read port
  assign elem_data  = mem[rd_ptr];

  //////////////////////////////////////////////////
  // Header strobe and sticky flags
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      vec_start <= 1'b0;
      status    <= '0;
    end else begin
      vec_start <= hdr_accept;
      if (hdr_accept) begin
        // New vector starts clean
        status <= '0;
      end else begin
        if (hdr_in) begin
          status.header_drop <= 1'b1;
        end
        if (elem_in && !push) begin
          status.overflow <= 1'b1;
        end
      end
    end
  end

  // Header fields held for the controller
  always_ff @(posedge CLK) begin
    if (hdr_accept) begin
      vec_header <= hdr_word;
    end
  end

  //////////////////////////////////////////////////
  // Circular buffer
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (hdr_accept) begin
      // Leftovers from before the header are discarded
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + ADDR_W'(1);
      end
      if (elem_pop) begin
        rd_ptr <= rd_ptr + ADDR_W'(1);
      end
      case ({push, elem_pop})
        2'b10:   count <= count + (ADDR_W+1)'(1);
        2'b01:   count <= count - (ADDR_W+1)'(1);
        default: count <= count;
      endcase
    end
  end

  // Storage array
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= elem_word;
    end
  end

endmodule

`default_nettype wire

// ==== source/ntm_modular_multiplier.sv ====
// Iterative double-and-add modular multiplier, one operand bit per cycle
`timescale 1ns/100ps
`default_nettype none

module ntm_modular_multiplier (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                start,
  input  logic [ntm_product_pkg::DATA_SIZE-1:0] data_a,
  input  logic [ntm_product_pkg::DATA_SIZE-1:0] data_b,
  input  logic [ntm_product_pkg::DATA_SIZE-1:0] modulo,
  output logic                                done,
  output logic [ntm_product_pkg::DATA_SIZE-1:0] product
);

  import ntm_product_pkg::*;

  localparam int IDX_W = $clog2(DATA_SIZE);

  logic [DATA_SIZE-1:0] acc_q;
  logic [DATA_SIZE-1:0] a_q;
  logic [DATA_SIZE-1:0] b_q;
  logic [DATA_SIZE-1:0] m_q;
  logic [IDX_W-1:0]     bit_idx;
  logic                 running;
  logic                 wrap_up;

  //////////////////////////////////////////////////
  // One step: acc = 2*acc (+a) mod m
  //////////////////////////////////////////////////

  function automatic logic [DATA_SIZE-1:0] mod_step(
    input logic [DATA_SIZE-1:0] acc,
    input logic                 add_en,
    input logic [DATA_SIZE-1:0] a,
    input logic [DATA_SIZE-1:0] m
  );
    logic [DATA_SIZE:0]   dbl;
    logic [DATA_SIZE-1:0] dbl_red;
    logic [DATA_SIZE:0]   sum;
    logic [DATA_SIZE-1:0] sum_red;
    // Doubling stays below 2m when acc < m
    dbl     = {acc, 1'b0};
    dbl_red = (dbl >= {1'b0, m}) ? DATA_SIZE'(dbl - {1'b0, m}) : dbl[DATA_SIZE-1:0];
    // Same bound for the optional add
    sum     = {1'b0, dbl_red} + (add_en ? {1'b0, a} : '0);
    sum_red = (sum >= {1'b0, m}) ? DATA_SIZE'(sum - {1'b0, m}) : sum[DATA_SIZE-1:0];
    return sum_red;
  endfunction

  //////////////////////////////////////////////////
  // Bit sequencing
  //////////////////////////////////////////////////

  // MSB is consumed at the start edge, the rest while running
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      running <= 1'b0;
      wrap_up <= 1'b0;
      done    <= 1'b0;
      bit_idx <= '0;
    end else begin
      done    <= wrap_up;
      wrap_up <= running && (bit_idx == '0);
      if (start) begin
        running <= 1'b1;
        bit_idx <= IDX_W'(DATA_SIZE - 2);
      end else if (running) begin
        if (bit_idx == '0) begin
          running <= 1'b0;
        end else begin
          bit_idx <= bit_idx - IDX_W'(1);
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Datapath
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (start) begin
      a_q   <= data_a;
      b_q   <= data_b;
      m_q   <= modulo;
      // Accumulator starts at zero, so the first step only adds
      acc_q <= mod_step('0, data_b[DATA_SIZE-1], data_a, modulo);
    end else if (running) begin
      acc_q <= mod_step(acc_q, b_q[bit_idx], a_q, m_q);
    end
    // Extra cycle to present the result with done
    if (wrap_up) begin
      product <= acc_q;
    end
  end

endmodule

`default_nettype wire

// ==== source/ntm_product_controller.sv ====
// Vector FSM that folds each buffered element into a running modular product
`timescale 1ns/100ps
`default_nettype none

module ntm_product_controller (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                vec_start,
  input  ntm_product_pkg::ntm_header_t         vec_header,
  input  ntm_product_pkg::ntm_element_t        elem_data,
  input  logic                                elem_empty,
  input  logic                                mul_done,
  input  logic [ntm_product_pkg::DATA_SIZE-1:0] mul_product,
  output logic                                elem_pop,
  output logic                                mul_start,
  output logic [ntm_product_pkg::DATA_SIZE-1:0] mul_a,
  output logic [ntm_product_pkg::DATA_SIZE-1:0] mul_b,
  output logic [ntm_product_pkg::DATA_SIZE-1:0] mul_modulo,
  output logic                                prod_valid,
  output logic [ntm_product_pkg::DATA_SIZE-1:0] prod_value,
  output logic                                busy
);

  import ntm_product_pkg::*;

  // State encodings
  localparam logic [1:0] IDLE     = 2'd0;
  localparam logic [1:0] FETCH    = 2'd1;
  localparam logic [1:0] MULTIPLY = 2'd2;
  localparam logic [1:0] FINISH   = 2'd3;

  logic [1:0]           state;
  logic [DATA_SIZE-1:0] modulo_q;
  logic [DATA_SIZE-1:0] prod_q;
  logic [LEN_W-1:0]     length_q;
  logic [LEN_W-1:0]     count_q;
  logic [LEN_W-1:0]     count_next;
  logic                 last_elem;
  logic                 vec_load;

  //////////////////////////////////////////////////
  // Handshake outputs
  //////////////////////////////////////////////////

  // Pop and multiply in the same cycle, operands from the FIFO head
  assign elem_pop   = (state == FETCH) && !elem_empty;
  assign mul_start  = elem_pop;
  assign mul_a      = prod_q;
  assign mul_b      = elem_data.value;
  assign mul_modulo = modulo_q;

  assign prod_valid = (state == FINISH);
  assign prod_value = prod_q;
  // Covers the header strobe cycle as well
  assign busy       = vec_start || (state != IDLE);

  assign vec_load   = (state == IDLE) && vec_start;
  assign count_next = count_q + LEN_W'(1);
  assign last_elem  = (count_next == length_q);

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      length_q <= '0;
      count_q  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (vec_start) begin
            length_q <= vec_header.length;
            count_q  <= '0;
            // Empty vector goes straight to the result
            state    <= (vec_header.length == '0) ? FINISH : FETCH;
          end
        end
        FETCH: begin
          if (!elem_empty) begin
            state <= MULTIPLY;
          end
        end
        MULTIPLY: begin
          if (mul_done) begin
            count_q <= count_next;
            state   <= last_elem ? FINISH : FETCH;
          end
        end
        FINISH: begin
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Modulus and running product
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (vec_load) begin
      modulo_q <= vec_header.modulo;
      // 1 mod m, zero only for m of one
      prod_q   <= (vec_header.modulo > DATA_SIZE'(1)) ? DATA_SIZE'(1) : '0;
    end else if ((state == MULTIPLY) && mul_done) begin
      prod_q <= mul_product;
    end
  end

endmodule

`default_nettype wire

// ==== source/ntm_result_stage.sv ====
// Output side that registers the product with its status and strobes the result
`timescale 1ns/100ps
`default_nettype none

module ntm_result_stage (
  input  logic                                CLK,
  input  logic                                RST,
  input  logic                                prod_valid,
  input  logic [ntm_product_pkg::DATA_SIZE-1:0] prod_value,
  input  ntm_product_pkg::ntm_status_t         status,
  output logic                                out_valid,
  output ntm_product_pkg::ntm_result_t         out_result
);

  //////////////////////////////////////////////////
  // Result strobe
  //////////////////////////////////////////////////

  // One cycle after the controller finishes
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= prod_valid;
    end
  end

  //////////////////////////////////////////////////
  // Result payload
  //////////////////////////////////////////////////

  // Flags sampled with the product
  // Held until the next vector completes
  always_ff @(posedge CLK) begin
    if (prod_valid) begin
      out_result.value  <= prod_value;
      out_result.status <= status;
    end
  end

endmodule

`default_nettype wire

// ==== source/ntm_scalar_product_top.sv ====
// Modular product accelerator top with input FIFO, controller, multiplier and output
`timescale 1ns/100ps
`default_nettype none

module ntm_scalar_product_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                         CLK,
  input  logic                         RST,
  input  logic                         IN_VALID,
  input  ntm_product_pkg::ntm_in_beat_t IN_BEAT,
  output logic                         OUT_VALID,
  output ntm_product_pkg::ntm_result_t  OUT_RESULT,
  output logic                         BUSY
);

  import ntm_product_pkg::*;

  // FIFO to controller
  logic                 vec_start;
  ntm_header_t          vec_header;
  ntm_element_t         elem_data;
  logic                 elem_empty;
  logic                 elem_pop;
  ntm_status_t          status;

  // Controller to multiplier
  logic                 mul_start;
  logic [DATA_SIZE-1:0] mul_a;
  logic [DATA_SIZE-1:0] mul_b;
  logic [DATA_SIZE-1:0] mul_modulo;
  logic                 mul_done;
  logic [DATA_SIZE-1:0] mul_product;

  // Controller to result stage
  logic                 prod_valid;
  logic [DATA_SIZE-1:0] prod_value;
  logic                 ctrl_busy;

  // Busy through the cycle of the result strobe
  assign BUSY = ctrl_busy || OUT_VALID;

  //////////////////////////////////////////////////
  // Instances
  //////////////////////////////////////////////////

  ntm_element_fifo #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_element_fifo (
    .CLK        (CLK),
    .RST        (RST),
    .in_valid   (IN_VALID),
    .in_beat    (IN_BEAT),
    .elem_pop   (elem_pop),
    .busy       (ctrl_busy),
    .vec_start  (vec_start),
    .vec_header (vec_header),
    .elem_data  (elem_data),
    .elem_empty (elem_empty),
    .status     (status)
  );

  ntm_product_controller u_product_controller (
    .CLK         (CLK),
    .RST         (RST),
    .vec_start   (vec_start),
    .vec_header  (vec_header),
    .elem_data   (elem_data),
    .elem_empty  (elem_empty),
    .mul_done    (mul_done),
    .mul_product (mul_product),
    .elem_pop    (elem_pop),
    .mul_start   (mul_start),
    .mul_a       (mul_a),
    .mul_b       (mul_b),
    .mul_modulo  (mul_modulo),
    .prod_valid  (prod_valid),
    .prod_value  (prod_value),
    .busy        (ctrl_busy)
  );

  ntm_modular_multiplier u_modular_multiplier (
    .CLK     (CLK),
    .RST     (RST),
    .start   (mul_start),
    .data_a  (mul_a),
    .data_b  (mul_b),
    .modulo  (mul_modulo),
    .done    (mul_done),
    .product (mul_product)
  );

  ntm_result_stage u_result_stage (
    .CLK        (CLK),
    .RST        (RST),
    .prod_valid (prod_valid),
    .prod_value (prod_value),
    .status     (status),
    .out_valid  (OUT_VALID),
    .out_result (OUT_RESULT)
  );

endmodule

`default_nettype wire

// ==== testbench/ntm_scalar_product_properties.sv ====
// Protocol assertions bound into the modular product accelerator top level
`timescale 1ns/100ps
`default_nettype none

module ntm_scalar_product_properties (
  input logic CLK,
  input logic RST,
  input logic out_valid,
  input logic busy,
  input logic mul_start,
  input logic mul_done,
  input logic elem_pop,
  input logic elem_empty
);

  import ntm_product_pkg::*;

  // Failure counts per rule
  int unsigned single_out_fails = 0;
  int unsigned mul_lat_fails    = 0;
  int unsigned mul_src_fails    = 0;
  int unsigned pop_fails        = 0;
  int unsigned busy_fails       = 0;
  int unsigned failures;

  assign failures = single_out_fails + mul_lat_fails + mul_src_fails + pop_fails + busy_fails;

  //////////////////////////////////////////////////
  // Output strobe
  //////////////////////////////////////////////////

  // Result strobe lasts exactly one cycle
  a_single_out: assert property (@(posedge CLK) disable iff (RST) out_valid |=> !out_valid)
    else begin
      single_out_fails = single_out_fails + 1;
      $error("OUT_VALID high in two consecutive cycles");
    end

  // Result only at the end of an open busy window
  a_out_busy: assert property (@(posedge CLK) disable iff (RST) out_valid |-> $past(busy))
    else begin
      busy_fails = busy_fails + 1;
      $error("OUT_VALID without BUSY in the cycle before");
    end

  //////////////////////////////////////////////////
  // Multiplier and FIFO handshakes
  //////////////////////////////////////////////////

  // Fixed multiplier latency both ways
  a_mul_lat: assert property (@(posedge CLK) disable iff (RST)
                              mul_start |-> ##(DATA_SIZE+1) mul_done)
    else begin
      mul_lat_fails = mul_lat_fails + 1;
      $error("mul_done missing DATA_SIZE+1 cycles after mul_start");
    end

  a_mul_src: assert property (@(posedge CLK) disable iff (RST)
                              mul_done |-> $past(mul_start, DATA_SIZE+1))
    else begin
      mul_src_fails = mul_src_fails + 1;
      $error("mul_done without mul_start DATA_SIZE+1 cycles before");
    end

  // No pop from an empty FIFO
  // One pop per multiplication, never two in a row
  a_pop: assert property (@(posedge CLK) disable iff (RST)
                          elem_pop |-> !elem_empty ##1 !elem_pop)
    else begin
      pop_fails = pop_fails + 1;
      $error("elem_pop while elem_empty is high or in two consecutive cycles");
    end

endmodule

bind ntm_scalar_product_top ntm_scalar_product_properties u_properties (
  .CLK        (CLK),
  .RST        (RST),
  .out_valid  (OUT_VALID),
  .busy       (BUSY),
  .mul_start  (mul_start),
  .mul_done   (mul_done),
  .elem_pop   (elem_pop),
  .elem_empty (elem_empty)
);

`default_nettype wire

// ==== testbench/ntm_scalar_product_tb.sv ====
// Testbench for the modular product accelerator with file-driven vectors and expectations
`timescale 1ns/100ps
`default_nettype none

module ntm_scalar_product_tb;

  import ntm_product_pkg::*;

  localparam int FIFO_DEPTH   = 4;
  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int TIMEOUT      = 2000;
  localparam int REC_WORDS    = 1024;
  localparam int FILLER_GAP   = 20;
  localparam int EMPTY_LAT    = 3;

  // Record kinds in the vector file
  localparam int KIND_END      = 0;
  localparam int KIND_PLAIN    = 1;
  localparam int KIND_OVERFLOW = 2;
  localparam int KIND_HDR_DROP = 3;

  // Header pushed into the middle of a vector
  localparam logic [DATA_SIZE-1:0] STRAY_MODULO = 16'd5;
  localparam logic [LEN_W-1:0]     STRAY_LENGTH = 8'd9;

  logic         CLK;
  logic         RST;
  logic         in_valid;
  ntm_in_beat_t in_beat;
  logic         out_valid;
  ntm_result_t  out_result;
  logic         busy;

  logic [31:0]  rec [REC_WORDS];
  int           rd_idx;
  int           vec_num;
  int           error_count;

  ntm_scalar_product_top #(
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_ntm_scalar_product_top (
    .CLK        (CLK),
    .RST        (RST),
    .IN_VALID   (in_valid),
    .IN_BEAT    (in_beat),
    .OUT_VALID  (out_valid),
    .OUT_RESULT (out_result),
    .BUSY       (busy)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display(">>> FAIL");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      error_count++;
      stop_with_failure($sformatf("mismatch %s expected 0x%0h actual 0x%0h",
                                  name, expected, actual));
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Next word of the vector file
  task automatic take_word(output logic [31:0] word);
    if (rd_idx >= REC_WORDS) begin
      word = '0;
      stop_with_failure("vector file runs past the end of the stimulus buffer");
    end else begin
      word = rec[rd_idx];
      rd_idx++;
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      #1;
    end
  endtask

  // One-cycle strobe of whatever beat is loaded
  task automatic pulse_beat();
    in_valid = 1'b1;
    @(posedge CLK);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic load_element(input logic [DATA_SIZE-1:0] value);
    ntm_element_t elem;
    elem.reserved           = '0;
    elem.value              = value;
    in_beat.is_header       = 1'b0;
    in_beat.word.element    = elem;
  endtask

  task automatic send_element(input logic [DATA_SIZE-1:0] value);
    load_element(value);
    pulse_beat();
  endtask

  task automatic send_header(input logic [DATA_SIZE-1:0] modulo, input logic [LEN_W-1:0] length);
    ntm_header_t hdr;
    hdr.length          = length;
    hdr.reserved        = '0;
    hdr.modulo          = modulo;
    in_beat.is_header   = 1'b1;
    in_beat.word.header = hdr;
    pulse_beat();
  endtask

  // Headers go in only once BUSY is low
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (busy && (cycles < TIMEOUT)) begin
      @(posedge CLK);
      #1;
      cycles++;
    end
    if (busy) begin
      stop_with_failure("BUSY did not drop within timeout");
    end
  endtask

  // Slow filler elements keep an overloaded vector going
  task automatic wait_result(input logic fillers, output ntm_result_t res, output time t_seen);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    res    = '0;
    t_seen = 0;
    while (!seen && (cycles < TIMEOUT)) begin
      @(posedge CLK);
      #1;
      in_valid = 1'b0;
      cycles++;
      if (out_valid) begin
        seen   = 1'b1;
        res    = out_result;
        t_seen = $time;
      end else if (fillers && ((cycles % FILLER_GAP) == 0)) begin
        load_element(16'd1);
        in_valid = 1'b1;
      end
    end
    if (!seen) begin
      stop_with_failure("no result strobe within timeout");
    end
  endtask

  //////////////////////////////////////////////////
  // One vector record
  //////////////////////////////////////////////////

  task automatic run_vector(input int kind);
    logic [31:0]          word;
    logic [DATA_SIZE-1:0] modulo;
    logic [DATA_SIZE-1:0] elems [256];
    logic [31:0]          exp_value;
    logic [31:0]          exp_flags;
    int                   length;
    int                   gap;
    int                   i;
    ntm_result_t          res;
    time                  t_hdr;
    time                  t_out;
    string                tname;

    vec_num++;
    tname = $sformatf("vector %0d", vec_num);
    take_word(word);
    modulo = word[DATA_SIZE-1:0];
    take_word(word);
    length = int'(word[LEN_W-1:0]);
    for (i = 0; i < length; i++) begin
      take_word(word);
      elems[i] = word[DATA_SIZE-1:0];
    end
    take_word(word);
    gap = int'(word[15:0]);
    take_word(exp_value);
    take_word(exp_flags);

    wait_idle();
    t_hdr = $time;
    send_header(modulo, LEN_W'(length));
    for (i = 0; i < length; i++) begin
      // Stray header lands while the vector is busy
      if ((kind == KIND_HDR_DROP) && (i == length / 2)) begin
        send_header(STRAY_MODULO, STRAY_LENGTH);
      end
      send_element(elems[i]);
      if (i < length - 1) begin
        idle_cycles(gap);
      end
    end
    wait_result(kind == KIND_OVERFLOW, res, t_out);

    if (length == 0) begin
      check_value({tname, " empty latency"}, EMPTY_LAT, int'((t_out - t_hdr) / CLK_PERIOD));
    end
    if (kind == KIND_OVERFLOW) begin
      check_value({tname, " overflow flag"}, 32'(exp_flags[1]), 32'(res.status.overflow));
    end else begin
      check_value({tname, " value"}, exp_value, 32'(res.value));
      check_value({tname, " flags"}, exp_flags, 32'(res.status));
    end
    check_value({tname, " assertion failures"}, 0,
                u_ntm_scalar_product_top.u_properties.failures);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin : stimulus
    logic [31:0] word;
    logic        reading;
    RST         = 1'b1;
    in_valid    = 1'b0;
    in_beat     = '0;
    rd_idx      = 0;
    vec_num     = 0;
    error_count = 0;
    reading     = 1'b1;
    $readmemh("testbench/product_input.txt", rec);
    repeat (RESET_CYCLES) @(posedge CLK);
    #1;
    RST = 1'b0;
    idle_cycles(2);
    check_value("reset out_valid", 0, 32'(out_valid));
    check_value("reset busy", 0, 32'(busy));

    while (reading) begin
      take_word(word);
      if ($isunknown(word)) begin
        stop_with_failure("vector file holds unknown data where a record kind belongs");
      end else if (word == KIND_END) begin
        reading = 1'b0;
      end else if ((word == KIND_PLAIN) || (word == KIND_OVERFLOW) || (word == KIND_HDR_DROP)) begin
        run_vector(int'(word));
      end else begin
        stop_with_failure($sformatf("unknown record kind 0x%0h in vector file", word));
      end
    end
    if (vec_num == 0) begin
      stop_with_failure("no vectors read from the vector file");
    end

    idle_cycles(4);
    // Late assertion failures count as well
    if ((error_count == 0) && (u_ntm_scalar_product_top.u_properties.failures == 0)) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
source/ntm_product_pkg.sv
source/ntm_element_fifo.sv
source/ntm_modular_multiplier.sv
source/ntm_product_controller.sv
source/ntm_result_stage.sv
source/ntm_scalar_product_top.sv
testbench/ntm_scalar_product_properties.sv
testbench/ntm_scalar_product_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the modular product testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module ntm_scalar_product_tb -Mdir "$OBJ" -f build.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/Vntm_scalar_product_tb" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q '^>>> PASS$' "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== testbench/product_input.txt ====
// kind m n e0..e(n-1) gap expected flags, all hex, one vector per line
// kind 1 plain, 2 burst past FIFO depth, 3 stray header mid-vector, 0 ends; flags {overflow, header_drop}

// Basic products at wide gaps
1 0007 03 0003 0005 0006 1e 0006 0
1 0065 04 0002 0003 0004 0005 19 0013 0
1 fff1 02 1234 0002 20 2468 0
1 03e8 03 03e7 03e7 0002 18 0002 0
1 ffff 02 fffe fffe 1c 0001 0

// Empty vectors give 1, single vectors give the element
1 000d 00 00 0001 0
1 0002 00 00 0001 0
1 003b 01 002a 10 002a 0

// Back-to-back elements, n up to FIFO depth
1 000b 04 0002 0003 0004 0005 00 000a 0
1 0061 03 0050 005a 0003 00 0042 0
1 7fff 03 4000 4000 0002 00 4000 0

// Burst of FIFO depth plus two, only the overflow flag counts
2 0011 06 0001 0002 0003 0004 0005 0006 00 0000 2

// Flags clear on the next header
1 0013 02 0005 0007 04 0010 0

// Stray header mid-vector leaves the product alone
3 001d 04 0003 0004 0005 0006 14 000c 1

// Flags clear again
1 0025 03 0006 0007 0008 02 0003 0

// End of records
0
